// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           valid,
    output logic                           ready,
    input  logic                           buf_we_op,
    input  logic                           hit,
    input  logic                           hit_way,
    input  logic                           victim_way,
    input  logic                           mem_addr_ok,
    input  logic                           mem_data_ok,
    output logic                           buf_we,
    output logic [dcache_pkg::way_num-1:0] tag_we,
    output logic [dcache_pkg::way_num-1:0] data_we,
    output logic                           refill,
    output logic                           lru_use,
    output logic                           use_way,
    output logic                           rdata_valid,
    output logic                           mem_req,
    output logic                           mem_wr
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss_read,
        miss_wait,
        refill_done,
        mem_write
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state and strobes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state  = state;
        ready       = 1'b0;
        buf_we      = 1'b0;
        tag_we      = '0;
        data_we     = '0;
        refill      = 1'b0;
        lru_use     = 1'b0;
        use_way     = 1'b0;
        rdata_valid = 1'b0;
        mem_req     = 1'b0;
        mem_wr      = 1'b0;

        case (state)
            // refill_done is the settle cycle after a line fill
            idle, refill_done: begin
                ready      = 1'b1;
                buf_we     = valid;
                next_state = valid ? lookup : idle;
            end

            lookup: begin
                if (buf_we_op) begin
                    // write through, and update the line only on a hit
                    mem_req    = 1'b1;
                    mem_wr     = 1'b1;
                    next_state = mem_addr_ok ? idle : mem_write;
                    if (hit) begin
                        data_we[hit_way] = 1'b1;
                        lru_use          = 1'b1;
                        use_way          = hit_way;
                    end
                end else if (hit) begin
                    // read hit, overlap with the next request
                    rdata_valid = 1'b1;
                    lru_use     = 1'b1;
                    use_way     = hit_way;
                    ready       = 1'b1;
                    buf_we      = valid;
                    next_state  = valid ? lookup : idle;
                end else begin
                    mem_req    = 1'b1;
                    next_state = mem_addr_ok ? miss_wait : miss_read;
                end
            end

            miss_read: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    next_state = miss_wait;
                end
            end

            miss_wait: begin
                if (mem_data_ok) begin
                    // fill the victim way and forward the word
                    refill              = 1'b1;
                    tag_we[victim_way]  = 1'b1;
                    data_we[victim_way] = 1'b1;
                    lru_use             = 1'b1;
                    use_way             = victim_way;
                    rdata_valid         = 1'b1;
                    next_state          = refill_done;
                end
            end

            mem_write: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (mem_addr_ok) begin
                    next_state = idle;
                end
            end

            default: begin
                next_state = idle;
            end
        endcase
    end

endmodule

// ==== dcache_lookup.sv ====
`timescale 1ns/1ps

module dcache_lookup #(
    parameter int index_width  = dcache_pkg::index_width_def,
    parameter int offset_width = dcache_pkg::offset_width_def
) (
    input  dcache_pkg::word_t      buf_addr,
    input  dcache_pkg::word_t      buf_wdata,
    input  logic [3:0]             buf_wstrb,
    input  dcache_pkg::tag_entry_t tag0,
    input  dcache_pkg::tag_entry_t tag1,
    input  dcache_pkg::line_t      line0,
    input  dcache_pkg::line_t      line1,
    input  dcache_pkg::line_t      mem_rdata,
    input  logic                   refill,
    output logic                   hit,
    output logic                   hit_way,
    output dcache_pkg::word_t      rword,
    output dcache_pkg::tag_entry_t new_tag,
    output dcache_pkg::line_t      new_line
);

    localparam int tag_width = 32 - index_width - offset_width - 2;

    logic [tag_width-1:0]    addr_tag;
    logic [offset_width-1:0] word_sel;
    logic                    hit0;
    logic                    hit1;
    dcache_pkg::line_t       hit_line;
    dcache_pkg::line_t       merged;

    assign addr_tag = buf_addr[31 -: tag_width];
    assign word_sel = buf_addr[2 +: offset_width];

    //////////////////////////////////////////////////////////////////////
    // tag compare
    //////////////////////////////////////////////////////////////////////

    assign hit0    = tag0.valid && (tag0.tag == addr_tag);
    assign hit1    = tag1.valid && (tag1.tag == addr_tag);
    assign hit     = hit0 | hit1;
    assign hit_way = hit1;

    assign hit_line = hit_way ? line1 : line0;

    // refill forwards the requested word straight from memory
    assign rword = refill ? mem_rdata[word_sel] : hit_line[word_sel];

    //////////////////////////////////////////////////////////////////////
    // line to write back into the array
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        merged = hit_line;
        for (int b = 0; b < 4; b++) begin
            if (buf_wstrb[b]) begin
                merged[word_sel][8*b +: 8] = buf_wdata[8*b +: 8];
            end
        end
    end

    assign new_line      = refill ? mem_rdata : merged;
    assign new_tag.valid = 1'b1;
    assign new_tag.tag   = addr_tag;

endmodule

// ==== dcache_lru.sv ====
`timescale 1ns/1ps

module dcache_lru #(
    parameter int index_width = dcache_pkg::index_width_def
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] index,
    input  logic                   lru_use,
    input  logic                   use_way,
    output logic                   victim_way
);

    // one bit per set holding the most recently used way
    logic [2**index_width-1:0] last_used;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            last_used <= '0;
        end else if (lru_use) begin
            last_used[index] <= use_way;
        end
    end

    // evict whichever way was not touched last
    assign victim_way = ~last_used[index];

endmodule

// ==== dcache_pkg.sv ====
package dcache_pkg;

    //////////////////////////////////////////////////////////////////////
    // geometry defaults
    //////////////////////////////////////////////////////////////////////

    // set index bits
    localparam int index_width_def = 4;
    // word offset bits inside a line, four words per line
    localparam int offset_width_def = 2;
    // two ways, the lru bit and hit logic assume this
    localparam int way_num = 2;
    // remaining address bits above index, offset and byte select
    localparam int tag_width_def = 32 - index_width_def - offset_width_def - 2;

    //////////////////////////////////////////////////////////////////////
    // payload types
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;

    // one tag array entry
    typedef struct packed {
        logic                     valid;
        logic [tag_width_def-1:0] tag;
    } tag_entry_t;

    // full cache line, word 0 in the low bits
    typedef word_t [2**offset_width_def-1:0] line_t;

endpackage

// ==== dcache_req_buf.sv ====
`timescale 1ns/1ps

module dcache_req_buf #(
    parameter int index_width  = dcache_pkg::index_width_def,
    parameter int offset_width = dcache_pkg::offset_width_def
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                buf_we,
    input  dcache_pkg::word_t   addr,
    input  dcache_pkg::word_t   wdata,
    input  logic [3:0]          wstrb,
    input  logic                we,
    output dcache_pkg::word_t   buf_addr,
    output dcache_pkg::word_t   buf_wdata,
    output logic [3:0]          buf_wstrb,
    output logic                buf_we_op
);

    localparam int tag_width = 32 - index_width - offset_width - 2;

    logic [tag_width-1:0]    tag_q;
    logic [index_width-1:0]  index_q;
    logic [offset_width-1:0] offset_q;

    // address kept as fields, byte select dropped since accesses are full words
    always_ff @(posedge clk) begin
        if (buf_we) begin
            tag_q     <= addr[31 -: tag_width];
            index_q   <= addr[offset_width+2 +: index_width];
            offset_q  <= addr[2 +: offset_width];
            buf_wdata <= wdata;
            buf_wstrb <= wstrb;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_we_op <= 1'b0;
        end else if (buf_we) begin
            buf_we_op <= we;
        end
    end

    assign buf_addr = {tag_q, index_q, offset_q, 2'b00};

endmodule

// ==== dcache_sram.sv ====
`timescale 1ns/1ps

module dcache_sram #(
    parameter int  depth_width = dcache_pkg::index_width_def,
    parameter type payload_t   = dcache_pkg::word_t
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   we,
    input  logic [depth_width-1:0] raddr,
    input  logic [depth_width-1:0] waddr,
    input  payload_t               wdata,
    output payload_t               rdata
);

    localparam int depth = 2**depth_width;

    payload_t store [depth];

    // cleared on reset so every tag entry starts invalid
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < depth; i++) begin
                store[i] <= '0;
            end
        end else if (we) begin
            store[waddr] <= wdata;
        end
    end

    // registered read, old contents on a same-address write
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rdata <= '0;
        end else begin
            rdata <= store[raddr];
        end
    end

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
    parameter int index_width  = dcache_pkg::index_width_def,
    parameter int offset_width = dcache_pkg::offset_width_def
) (
    input  logic              clk,
    input  logic              rstn,
    // pipeline side
    input  logic              valid,
    output logic              ready,
    input  dcache_pkg::word_t addr,
    input  dcache_pkg::word_t wdata,
    input  logic [3:0]        wstrb,
    input  logic              we,
    output dcache_pkg::word_t rdata,
    output logic              rdata_valid,
    // memory side
    output logic              mem_req,
    output logic              mem_wr,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_wdata,
    output logic [3:0]        mem_wstrb,
    input  logic              mem_addr_ok,
    input  logic              mem_data_ok,
    input  dcache_pkg::line_t mem_rdata
);

    localparam int way_num = dcache_pkg::way_num;

    dcache_pkg::word_t      buf_addr;
    dcache_pkg::word_t      buf_wdata;
    logic [3:0]             buf_wstrb;
    logic                   buf_we_op;
    logic                   buf_we;
    logic [way_num-1:0]     tag_we;
    logic [way_num-1:0]     data_we;
    logic                   refill;
    logic                   lru_use;
    logic                   use_way;
    logic                   hit;
    logic                   hit_way;
    logic                   victim_way;
    logic [index_width-1:0] rd_index;
    logic [index_width-1:0] buf_index;
    dcache_pkg::tag_entry_t tag_rd [way_num];
    dcache_pkg::line_t      line_rd [way_num];
    dcache_pkg::tag_entry_t new_tag;
    dcache_pkg::line_t      new_line;

    // arrays are read with the incoming address, written at the buffered one
    assign rd_index  = addr[offset_width+2 +: index_width];
    assign buf_index = buf_addr[offset_width+2 +: index_width];

    // line-aligned address for reads, word address for writes
    assign mem_addr  = buf_we_op ? buf_addr :
                       {buf_addr[31:offset_width+2], {(offset_width+2){1'b0}}};
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

    dcache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .valid(valid), .ready(ready),
        .buf_we_op(buf_we_op), .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .buf_we(buf_we),
        .tag_we(tag_we), .data_we(data_we), .refill(refill), .lru_use(lru_use),
        .use_way(use_way), .rdata_valid(rdata_valid), .mem_req(mem_req), .mem_wr(mem_wr)
    );

    dcache_req_buf #(.index_width(index_width), .offset_width(offset_width)) u_req_buf (
        .clk(clk), .rstn(rstn), .buf_we(buf_we), .addr(addr), .wdata(wdata),
        .wstrb(wstrb), .we(we), .buf_addr(buf_addr), .buf_wdata(buf_wdata),
        .buf_wstrb(buf_wstrb), .buf_we_op(buf_we_op)
    );

    //////////////////////////////////////////////////////////////////////
    // per-way tag and data storage
    //////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < way_num; w++) begin : g_way
        dcache_sram #(
            .depth_width(index_width), .payload_t(dcache_pkg::tag_entry_t)
        ) u_tag (
            .clk(clk), .rstn(rstn), .we(tag_we[w]), .raddr(rd_index),
            .waddr(buf_index), .wdata(new_tag), .rdata(tag_rd[w])
        );

        dcache_sram #(
            .depth_width(index_width), .payload_t(dcache_pkg::line_t)
        ) u_data (
            .clk(clk), .rstn(rstn), .we(data_we[w]), .raddr(rd_index),
            .waddr(buf_index), .wdata(new_line), .rdata(line_rd[w])
        );
    end

    dcache_lookup #(.index_width(index_width), .offset_width(offset_width)) u_lookup (
        .buf_addr(buf_addr), .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb),
        .tag0(tag_rd[0]), .tag1(tag_rd[1]), .line0(line_rd[0]), .line1(line_rd[1]),
        .mem_rdata(mem_rdata), .refill(refill), .hit(hit), .hit_way(hit_way),
        .rword(rdata), .new_tag(new_tag), .new_line(new_line)
    );

    dcache_lru #(.index_width(index_width)) u_lru (
        .clk(clk), .rstn(rstn), .index(buf_index), .lru_use(lru_use),
        .use_way(use_way), .victim_way(victim_way)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the dcache testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_dcache -f sources.f \
    -Mdir obj_dir -o tb_dcache_sim \
    && ./obj_dir/tb_dcache_sim | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sources.f ====
dcache_pkg.sv
dcache_req_buf.sv
dcache_sram.sv
dcache_lookup.sv
dcache_lru.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 4;
    localparam int n_directed   = 14;
    localparam int n_random     = 300;
    localparam int idx_w        = dcache_pkg::index_width_def;
    localparam int off_w        = dcache_pkg::offset_width_def;
    localparam int tag_lsb      = idx_w + off_w + 2;
    localparam int n_sets       = 2**idx_w;
    localparam int mem_aw       = 10;
    localparam int mem_words    = 2**mem_aw;

    // one accepted request and what the reference model expects from it
    typedef struct packed {
        logic              is_write;
        logic              hit;
        dcache_pkg::word_t addr;
        dcache_pkg::word_t data;
        logic [3:0]        strb;
        int                cycle;
    } expect_t;

    logic              clk = 1'b0;
    logic              rstn;
    logic              valid;
    logic              ready;
    dcache_pkg::word_t addr;
    dcache_pkg::word_t wdata;
    logic [3:0]        wstrb;
    logic              we;
    dcache_pkg::word_t rdata;
    logic              rdata_valid;
    logic              mem_req;
    logic              mem_wr;
    dcache_pkg::word_t mem_addr;
    dcache_pkg::word_t mem_wdata;
    logic [3:0]        mem_wstrb;
    logic              mem_addr_ok;
    logic              mem_data_ok;
    dcache_pkg::line_t mem_rdata;

    dcache_pkg::word_t                    mem_model [mem_words];
    logic [dcache_pkg::tag_width_def-1:0] model_tag [2][n_sets];
    logic                                 model_valid [2][n_sets];
    logic                                 model_lru [n_sets];
    expect_t                              pending [$];
    logic                                 fetched = 1'b0;
    int                                   cycles = 0;
    int                                   accept_cycle = 0;

    dcache_top dut (
        .clk(clk), .rstn(rstn), .valid(valid), .ready(ready), .addr(addr),
        .wdata(wdata), .wstrb(wstrb), .we(we), .rdata(rdata), .rdata_valid(rdata_valid),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb), .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .mem_rdata(mem_rdata)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    //////////////////////////////////////////////////////////////////////
    // failure reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rdata(input string name, input dcache_pkg::word_t exp,
                               input dcache_pkg::word_t act);
        if (act !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_mem_word(input string name, input dcache_pkg::word_t exp,
                                  input dcache_pkg::word_t act);
        if (act !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s expected %b actual %b",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_strobe(input string name, input logic [3:0] exp,
                                input logic [3:0] act);
        if (act !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                               $time, name, exp, act));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic dcache_pkg::word_t make_addr(input int tag, input int idx, input int off);
        return dcache_pkg::word_t'((tag << tag_lsb) | (idx << (off_w + 2)) | (off << 2));
    endfunction

    // memory fill that mixes every address bit
    function automatic dcache_pkg::word_t fill_word(input int i);
        dcache_pkg::word_t a;
        a = dcache_pkg::word_t'(i) << 2;
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[31:16]};
    endfunction

    task automatic model_access(input dcache_pkg::word_t a, input logic is_wr, output logic hit);
        int                                   set;
        logic                                 way;
        logic [dcache_pkg::tag_width_def-1:0] tag;
        set = int'(a[off_w + 2 +: idx_w]);
        tag = a[31:tag_lsb];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][set] && model_tag[w][set] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (hit) begin
            model_lru[set] = way;
        end else if (!is_wr) begin
            // a read miss fills the way not used last and a write miss leaves the cache alone
            way = ~model_lru[set];
            model_valid[way][set] = 1'b1;
            model_tag[way][set] = tag;
            model_lru[set] = way;
        end
    endtask

    // entered and left at a falling edge with valid kept up when gap is zero
    task automatic send_req(input dcache_pkg::word_t a, input logic w,
                            input dcache_pkg::word_t d, input logic [3:0] s, input int gap);
        logic    accepted;
        logic    hit_exp;
        expect_t e;
        if (gap > 0) begin
            valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
        valid = 1'b1;
        addr = a;
        we = w;
        wdata = d;
        wstrb = s;
        accepted = 1'b0;
        while (!accepted) begin
            #1;
            accepted = ready;
            if (!accepted) @(negedge clk);
        end
        accept_cycle = cycles;
        model_access(a, w, hit_exp);
        e.is_write = w;
        e.hit = hit_exp;
        e.addr = a;
        e.data = w ? d : mem_model[a[2 +: mem_aw]];
        e.strb = s;
        e.cycle = cycles;
        pending.push_back(e);
        @(negedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory responder
    //////////////////////////////////////////////////////////////////////

    initial begin : mem_responder
        int                delay;
        int                base;
        dcache_pkg::line_t fill_line;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            mem_addr_ok = 1'b0;
            mem_data_ok = 1'b0;
            if (rstn && mem_req) begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk);
                mem_addr_ok = 1'b1;
                if (mem_wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wstrb[b]) begin
                            mem_model[mem_addr[2 +: mem_aw]][8*b +: 8] = mem_wdata[8*b +: 8];
                        end
                    end
                end else begin
                    base = int'(mem_addr[2 +: mem_aw]);
                    delay = $urandom_range(4, 1);
                    @(negedge clk);
                    mem_addr_ok = 1'b0;
                    repeat (delay - 1) @(negedge clk);
                    for (int w = 0; w < 2**off_w; w++) begin
                        fill_line[w] = mem_model[base + w];
                    end
                    mem_rdata = fill_line;
                    mem_data_ok = 1'b1;
                end
            end
        end
    end

    // outputs are looked at 1 ns after the falling edge
    always begin : response_monitor
        @(negedge clk);
        #1;
        if (rstn && mem_req && mem_addr_ok) begin
            if (pending.size() == 0) begin
                stop_run("memory request seen while no request was in flight");
            end else if (pending[0].is_write) begin
                check_bit("mem_wr", 1'b1, mem_wr);
                check_mem_word("mem_addr", pending[0].addr, mem_addr);
                check_mem_word("mem_wdata", pending[0].data, mem_wdata);
                check_strobe("mem_wstrb", pending[0].strb, mem_wstrb);
                pending.delete(0);
            end else begin
                // a memory read means the cache missed
                check_bit("hit", pending[0].hit, 1'b0);
                check_bit("mem_wr", 1'b0, mem_wr);
                check_mem_word("mem_addr", pending[0].addr & ~32'((1 << (off_w + 2)) - 1),
                               mem_addr);
                fetched = 1'b1;
            end
        end
        if (rstn && rdata_valid) begin
            if (pending.size() == 0 || pending[0].is_write) begin
                stop_run("read data returned while no read was in flight");
            end else begin
                check_bit("hit", pending[0].hit, !fetched);
                check_rdata("rdata", pending[0].data, rdata);
                pending.delete(0);
                fetched = 1'b0;
            end
        end else if (pending.size() != 0 && !pending[0].is_write && pending[0].hit
                     && cycles > pending[0].cycle + 1) begin
            stop_run("read hit gave no data in the cycle after acceptance");
        end
    end

    initial begin : watchdog
        #(clk_period * (reset_cycles + (n_directed + n_random) * 40));
        stop_run("simulation hung, the watchdog time ran out");
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        int                r_tag;
        int                r_idx;
        int                r_off;
        int                r_gap;
        int                prev_accept;
        logic              r_wr;
        dcache_pkg::word_t r_data;
        dcache_pkg::word_t r_bits;
        void'($urandom(32'hbdf6));
        rstn = 1'b0;
        valid = 1'b0;
        addr = '0;
        wdata = '0;
        wstrb = '0;
        we = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            mem_model[i] = fill_word(i);
        end
        for (int s = 0; s < n_sets; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                model_valid[w][s] = 1'b0;
                model_tag[w][s] = '0;
            end
        end
        repeat (reset_cycles) @(negedge clk);
        rstn = 1'b1;
        #1;
        check_bit("ready", 1'b1, ready);
        check_bit("mem_req", 1'b0, mem_req);
        check_bit("rdata_valid", 1'b0, rdata_valid);
        @(negedge clk);

        // three lines in set 2 where the third evicts by lru
        send_req(make_addr(0, 2, 1), 1'b0, '0, '0, 0);
        send_req(make_addr(0, 2, 1), 1'b0, '0, '0, 1);
        send_req(make_addr(1, 2, 0), 1'b0, '0, '0, 0);
        send_req(make_addr(2, 2, 3), 1'b0, '0, '0, 2);
        send_req(make_addr(0, 2, 0), 1'b0, '0, '0, 0);
        send_req(make_addr(2, 2, 0), 1'b0, '0, '0, 1);
        // write hit and write miss each followed by a read back
        send_req(make_addr(2, 2, 0), 1'b1, 32'h1234_abcd, 4'b0101, 1);
        send_req(make_addr(2, 2, 0), 1'b0, '0, '0, 0);
        send_req(make_addr(3, 1, 2), 1'b1, 32'hc0de_5a11, 4'b1110, 0);
        send_req(make_addr(3, 1, 2), 1'b0, '0, '0, 0);
        // hits streaming with valid held high
        for (int w = 0; w < 4; w++) begin
            prev_accept = accept_cycle;
            send_req(make_addr(3, 1, w), 1'b0, '0, '0, 0);
            if (w > 0 && accept_cycle != prev_accept + 1) begin
                stop_run("back-to-back read hits were not accepted one per cycle");
            end
        end

        for (int i = 0; i < n_random; i++) begin
            r_tag = $urandom_range(3, 0);
            r_idx = $urandom_range(3, 0);
            r_off = $urandom_range(3, 0);
            r_gap = $urandom_range(2, 0);
            r_wr = ($urandom_range(9, 0) < 3);
            r_data = $urandom;
            r_bits = $urandom;
            send_req(make_addr(r_tag, r_idx, r_off), r_wr, r_data, r_bits[3:0], r_gap);
        end

        valid = 1'b0;
        while (pending.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule
